// ==== hw/core_pkg.sv ====
/* Core package for the RV32I datapath slice.
   Widths, opcode and ALU encodings, control bundle and immediate extractors. */
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    // ****************************************
    // Encodings
    // ****************************************
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        OPIMM  = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcode_e;

    // Code is {funct7[5], funct3}.
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        OR   = 4'b0110,
        AND  = 4'b0111,
        SUB  = 4'b1000,
        SRA  = 4'b1101
    } alu_op_e;

    typedef enum logic [2:0] {
        NONE, JUMP, BEQ, BNE, BLT, BGE, BLTU, BGEU
    } branch_e;

    typedef struct packed {
        logic [XLEN-1:0]       imm;
        alu_op_e               alu_op;
        logic [2:0]            funct3;   // Memory size and sign.
        branch_e               branch;
        logic                  mem_we;
        logic                  mem_re;
        logic                  reg_we;
        logic                  src1_pc;  // Operand a is pc.
        logic                  src2_imm; // Operand b is imm.
        logic                  link;     // Result is pc + 4.
        logic [REG_ADDR_W-1:0] rd;
    } ctrl_t;

    // ****************************************
    // Immediate extractors
    // ****************************************
    function automatic logic [XLEN-1:0] imm_i(input logic [31:0] insn);
        return {{20{insn[31]}}, insn[31:20]};
    endfunction

    function automatic logic [XLEN-1:0] imm_s(input logic [31:0] insn);
        return {{20{insn[31]}}, insn[31:25], insn[11:7]};
    endfunction

    function automatic logic [XLEN-1:0] imm_b(input logic [31:0] insn);
        return {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    endfunction

    function automatic logic [XLEN-1:0] imm_u(input logic [31:0] insn);
        return {insn[31:12], 12'b0};
    endfunction

    function automatic logic [XLEN-1:0] imm_j(input logic [31:0] insn);
        return {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    endfunction

endpackage

// ==== hw/stage_if.sv ====
/* Stage register buses of the slice.
   Decode to execute and execute to result, each with a forwarding return. */
interface dec_if;
    import core_pkg::*;

    logic                  valid;
    ctrl_t                 ctrl;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    logic                  fwd_valid; // Execute result back to decode.
    logic [REG_ADDR_W-1:0] fwd_rd;
    logic [XLEN-1:0]       fwd_data;

    modport source (output valid, ctrl, pc, op1, op2,
                    input fwd_valid, fwd_rd, fwd_data);
    modport sink (input valid, ctrl, pc, op1, op2,
                  output fwd_valid, fwd_rd, fwd_data);
endinterface

interface exe_if;
    import core_pkg::*;

    logic                  valid;
    ctrl_t                 ctrl;
    logic [XLEN-1:0]       result;
    logic [XLEN-1:0]       store_data;
    logic                  fwd_valid; // Writeback back to decode.
    logic [REG_ADDR_W-1:0] fwd_rd;
    logic [XLEN-1:0]       fwd_data;

    modport source (output valid, ctrl, result, store_data);
    modport sink (input valid, ctrl, result, store_data,
                  output fwd_valid, fwd_rd, fwd_data);
    modport fwd (input fwd_valid, fwd_rd, fwd_data);
endinterface

// ==== hw/reg_file.sv ====
/* Integer register file, 32 x 32, two read ports, x0 tied to zero. */
module reg_file (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [core_pkg::XLEN-1:0]       rs1_data,
    output logic [core_pkg::XLEN-1:0]       rs2_data,
    input  logic                            we,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [core_pkg::XLEN-1:0]       wdata
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst)
            regs <= '{default: '0};
        else if (we && waddr != '0)
            regs[waddr] <= wdata;
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hw/insn_decode.sv ====
/* Instruction decode stage.
   Builds the control bundle, resolves operands with forwarding, registers them. */
module insn_decode (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           instr_valid,
    input  logic [31:0]                    instr,
    input  logic [core_pkg::XLEN-1:0]      pc,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [core_pkg::XLEN-1:0]      rs1_data,
    input  logic [core_pkg::XLEN-1:0]      rs2_data,
    dec_if.source                          dec,
    exe_if.fwd                             wb
);
    import core_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    ctrl_t           ctrl;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;

    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // Execute first, then writeback, then the register file.
    function automatic logic [XLEN-1:0] resolve(input logic [REG_ADDR_W-1:0] addr,
                                                input logic [XLEN-1:0] rf_val);
        if (dec.fwd_valid && dec.fwd_rd == addr)
            return dec.fwd_data;
        else if (wb.fwd_valid && wb.fwd_rd == addr)
            return wb.fwd_data;
        return rf_val;
    endfunction

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ADD;
        ctrl.branch = NONE;
        ctrl.funct3 = funct3;
        ctrl.rd     = instr[11:7];
        case (opcode)
            LUI:    {ctrl.imm, ctrl.src2_imm, ctrl.reg_we} = {imm_u(instr), 2'b11};
            AUIPC:  {ctrl.imm, ctrl.src1_pc, ctrl.src2_imm, ctrl.reg_we} = {imm_u(instr), 3'b111};
            OPIMM: begin
                {ctrl.imm, ctrl.src2_imm, ctrl.reg_we} = {imm_i(instr), 2'b11};
                if (funct3 == 3'b101)
                    ctrl.alu_op = alu_op_e'({instr[30], funct3}); // Shifts only.
                else
                    ctrl.alu_op = alu_op_e'({1'b0, funct3});
            end
            OP: begin
                ctrl.alu_op = alu_op_e'({instr[30], funct3});
                ctrl.reg_we = 1'b1;
            end
            LOAD:   {ctrl.imm, ctrl.src2_imm, ctrl.mem_re, ctrl.reg_we} = {imm_i(instr), 3'b111};
            STORE:  {ctrl.imm, ctrl.src2_imm, ctrl.mem_we} = {imm_s(instr), 2'b11};
            JAL: begin
                {ctrl.imm, ctrl.src1_pc, ctrl.src2_imm} = {imm_j(instr), 2'b11};
                {ctrl.link, ctrl.reg_we, ctrl.branch} = {2'b11, JUMP};
            end
            JALR: begin
                {ctrl.imm, ctrl.src2_imm} = {imm_i(instr), 1'b1};
                {ctrl.link, ctrl.reg_we, ctrl.branch} = {2'b11, JUMP};
            end
            BRANCH: begin
                ctrl.imm    = imm_b(instr);
                ctrl.alu_op = SUB;
                case (funct3)
                    3'b000:  ctrl.branch = BEQ;
                    3'b001:  ctrl.branch = BNE;
                    3'b100:  ctrl.branch = BLT;
                    3'b101:  ctrl.branch = BGE;
                    3'b110:  ctrl.branch = BLTU;
                    3'b111:  ctrl.branch = BGEU;
                    default: ctrl.branch = NONE;
                endcase
            end
            default: ; // Plain add, no write.
        endcase
        ctrl.reg_we = ctrl.reg_we & (ctrl.rd != '0); // x0 is never written.
    end

    always_comb begin
        src1 = (opcode == LUI) ? '0 : resolve(rs1_addr, rs1_data);
        src2 = resolve(rs2_addr, rs2_data);
    end

    always_ff @(posedge clk) begin
        if (rst)
            dec.valid <= 1'b0;
        else
            dec.valid <= instr_valid;
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec.ctrl <= ctrl;
            dec.pc   <= pc;
            dec.op1  <= src1;
            dec.op2  <= src2;
        end
    end

endmodule

// ==== hw/alu_execute.sv ====
/* Execute stage with ALU, branch compare and target adder. */
module alu_execute (
    input  logic                      clk,
    input  logic                      rst,
    dec_if.sink                       dec,
    exe_if.source                     exe,
    output logic                      redirect_valid,
    output logic [core_pkg::XLEN-1:0] redirect_pc
);
    import core_pkg::*;

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] alu;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] target;
    logic            eq;
    logic            lt;
    logic            ltu;
    logic            taken;

    assign a = dec.ctrl.src1_pc  ? dec.pc       : dec.op1;
    assign b = dec.ctrl.src2_imm ? dec.ctrl.imm : dec.op2;

    always_comb begin
        case (dec.ctrl.alu_op)
            SUB:     alu = a - b;
            SLL:     alu = a << b[4:0];
            SLT:     alu = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            SLTU:    alu = {{(XLEN-1){1'b0}}, a < b};
            XOR:     alu = a ^ b;
            SRL:     alu = a >> b[4:0];
            SRA:     alu = $signed(a) >>> b[4:0];
            OR:      alu = a | b;
            AND:     alu = a & b;
            default: alu = a + b;
        endcase
    end

    // ****************************************
    // Branch resolution
    // ****************************************
    assign eq  = dec.op1 == dec.op2;
    assign lt  = $signed(dec.op1) < $signed(dec.op2);
    assign ltu = dec.op1 < dec.op2;

    always_comb begin
        case (dec.ctrl.branch)
            JUMP:    taken = 1'b1;
            BEQ:     taken = eq;
            BNE:     taken = !eq;
            BLT:     taken = lt;
            BGE:     taken = !lt;
            BLTU:    taken = ltu;
            BGEU:    taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    // JALR is the only jump with rs1 as base.
    assign target = (dec.ctrl.branch == JUMP && !dec.ctrl.src1_pc) ?
                    ((dec.op1 + dec.ctrl.imm) & ~32'd1) : (dec.pc + dec.ctrl.imm);
    assign result = dec.ctrl.link ? dec.pc + 32'd4 : alu;

    assign dec.fwd_valid = dec.valid & dec.ctrl.reg_we & ~dec.ctrl.mem_re; // Loads not ready.
    assign dec.fwd_rd    = dec.ctrl.rd;
    assign dec.fwd_data  = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            exe.valid      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            exe.valid      <= dec.valid;
            redirect_valid <= dec.valid & taken;
        end
    end

    always_ff @(posedge clk) begin
        exe.ctrl       <= dec.ctrl;
        exe.result     <= result;
        exe.store_data <= dec.op2;
        redirect_pc    <= target;
    end

endmodule

// ==== hw/result_stage.sv ====
/* Result stage: memory request, load shaping, register writeback and report. */
module result_stage (
    input  logic                            clk,
    input  logic                            rst,
    exe_if.sink                             exe,
    output logic                            mem_re,
    output logic                            mem_we,
    output logic [core_pkg::XLEN-1:0]       mem_addr,
    output logic [core_pkg::XLEN-1:0]       mem_wdata,
    output logic [1:0]                      mem_size,
    input  logic [core_pkg::XLEN-1:0]       mem_rdata,
    output logic                            rf_we,
    output logic [core_pkg::REG_ADDR_W-1:0] rf_waddr,
    output logic [core_pkg::XLEN-1:0]       rf_wdata,
    output logic                            wb_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [core_pkg::XLEN-1:0]       wb_data
);
    import core_pkg::*;

    logic [7:0]      lane_b;
    logic [15:0]     lane_h;
    logic [XLEN-1:0] load_val;

    assign mem_re    = exe.valid & exe.ctrl.mem_re;
    assign mem_we    = exe.valid & exe.ctrl.mem_we;
    assign mem_addr  = exe.result;
    assign mem_wdata = exe.store_data;   // Lanes are the memory's job.
    assign mem_size  = exe.ctrl.funct3[1:0];

    assign lane_b = mem_rdata[{exe.result[1:0], 3'b000} +: 8];
    assign lane_h = exe.result[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb begin
        case (exe.ctrl.funct3)
            3'b000:  load_val = {{24{lane_b[7]}}, lane_b};
            3'b001:  load_val = {{16{lane_h[15]}}, lane_h};
            3'b100:  load_val = {24'b0, lane_b};
            3'b101:  load_val = {16'b0, lane_h};
            default: load_val = mem_rdata;
        endcase
    end

    assign rf_we    = exe.valid & exe.ctrl.reg_we;
    assign rf_waddr = exe.ctrl.rd;
    assign rf_wdata = exe.ctrl.mem_re ? load_val : exe.result;

    assign exe.fwd_valid = rf_we;
    assign exe.fwd_rd    = rf_waddr;
    assign exe.fwd_data  = rf_wdata;

    always_ff @(posedge clk) begin
        if (rst)
            wb_valid <= 1'b0;
        else
            wb_valid <= rf_we;
    end

    always_ff @(posedge clk) begin
        wb_rd   <= rf_waddr;
        wb_data <= rf_wdata;
    end

endmodule

// ==== hw/rv_slice_top.sv ====
/* RV32I datapath slice top.
   Decode, execute and result stages around the register file. */
module rv_slice_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            instr_valid,
    input  logic [31:0]                     instr,
    input  logic [core_pkg::XLEN-1:0]       pc,
    input  logic [core_pkg::XLEN-1:0]       mem_rdata,
    output logic                            mem_re,
    output logic                            mem_we,
    output logic [core_pkg::XLEN-1:0]       mem_addr,
    output logic [core_pkg::XLEN-1:0]       mem_wdata,
    output logic [1:0]                      mem_size,
    output logic                            redirect_valid,
    output logic [core_pkg::XLEN-1:0]       redirect_pc,
    output logic                            wb_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [core_pkg::XLEN-1:0]       wb_data
);
    import core_pkg::*;

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;

    dec_if dec_bus ();
    exe_if exe_bus ();

    insn_decode u_decode (
        .clk, .rst, .instr_valid, .instr, .pc,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .dec (dec_bus),
        .wb  (exe_bus)
    );

    alu_execute u_execute (
        .clk, .rst,
        .dec (dec_bus),
        .exe (exe_bus),
        .redirect_valid, .redirect_pc
    );

    result_stage u_result (
        .clk, .rst,
        .exe (exe_bus),
        .mem_re, .mem_we, .mem_addr, .mem_wdata, .mem_size, .mem_rdata,
        .rf_we, .rf_waddr, .rf_wdata,
        .wb_valid, .wb_rd, .wb_data
    );

    reg_file u_regs (
        .clk, .rst, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata)
    );

endmodule

// ==== bench/rv_ref_model.sv ====
/* Reference model of the slice.
   Architectural registers, one-instruction executor and memory response. */
package rv_ref_model;
    import core_pkg::*;

    typedef struct packed {
        logic                  valid;
        logic                  mem_re;
        logic                  mem_we;
        logic [XLEN-1:0]       addr;
        logic [XLEN-1:0]       wdata;
        logic [1:0]            size;
        logic                  redirect;
        logic [XLEN-1:0]       target;
        logic                  wb;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       wb_data;
    } expect_t;

    logic [XLEN-1:0] arch_regs [NUM_REGS];

    function automatic void clear_regs();
        for (int i = 0; i < NUM_REGS; i++)
            arch_regs[i] = '0;
    endfunction

    // Every word address reads its own value.
    function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] w;
        w = {addr[XLEN-1:2], 2'b00};
        return (w * 32'h9E37_79B1) ^ {w[15:0], w[31:16]};
    endfunction

    function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        sa = a;
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt)
                    return sa >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // ****************************************
    // One instruction in program order
    // ****************************************
    function automatic expect_t exec_insn(input logic [31:0] insn, input logic [XLEN-1:0] pc);
        expect_t         e;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] word;
        logic [7:0]      lb;
        logic [15:0]     lh;
        logic [2:0]      f3;
        logic            wr;
        e       = '0;
        e.valid = 1'b1;
        e.rd    = insn[11:7];
        f3      = insn[14:12];
        a       = arch_regs[insn[19:15]];
        b       = arch_regs[insn[24:20]];
        wr      = 1'b1;
        res     = '0;
        case (insn[6:0])
            LUI:   res = imm_u(insn);
            AUIPC: res = pc + imm_u(insn);
            OPIMM: res = alu_ref(f3, insn[30] && f3 == 3'd5, a, imm_i(insn));
            OP:    res = alu_ref(f3, insn[30], a, b);
            LOAD: begin
                e.mem_re = 1'b1;
                e.addr   = a + imm_i(insn);
                e.size   = f3[1:0];
                word     = mem_word(e.addr);
                lb       = word >> (8 * e.addr[1:0]);
                lh       = e.addr[1] ? word[31:16] : word[15:0];
                case (f3)
                    3'd0:    res = {{24{lb[7]}}, lb};
                    3'd1:    res = {{16{lh[15]}}, lh};
                    3'd4:    res = {24'b0, lb};
                    3'd5:    res = {16'b0, lh};
                    default: res = word;
                endcase
            end
            STORE: begin
                wr       = 1'b0;
                e.mem_we = 1'b1;
                e.addr   = a + imm_s(insn);
                e.wdata  = b;
                e.size   = f3[1:0];
            end
            JAL: begin
                res        = pc + 32'd4;
                e.redirect = 1'b1;
                e.target   = pc + imm_j(insn);
            end
            JALR: begin
                res        = pc + 32'd4;
                e.redirect = 1'b1;
                e.target   = (a + imm_i(insn)) & ~32'd1;
            end
            BRANCH: begin
                wr       = 1'b0;
                e.target = pc + imm_b(insn);
                case (f3)
                    3'd0:    e.redirect = a == b;
                    3'd1:    e.redirect = a != b;
                    3'd4:    e.redirect = $signed(a) < $signed(b);
                    3'd5:    e.redirect = $signed(a) >= $signed(b);
                    3'd6:    e.redirect = a < b;
                    default: e.redirect = a >= b;
                endcase
            end
            default: wr = 1'b0;
        endcase
        e.wb      = wr && e.rd != '0;
        e.wb_data = res;
        if (e.wb)
            arch_regs[e.rd] = res;
        return e;
    endfunction

endpackage

// ==== bench/tb_rv_slice.sv ====
/* Testbench for the RV32I slice.
   LFSR instruction stream checked against the reference model. */
module tb_rv_slice;
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;
    import rv_ref_model::*;

    typedef enum int {K_ALU, K_LOAD, K_STORE, K_BRANCH, K_ZERO, K_MIXED} test_kind_e;

    logic                  clk;
    logic                  rst;
    logic                  instr_valid;
    logic [31:0]           instr;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       mem_rdata;
    logic                  mem_re;
    logic                  mem_we;
    logic [XLEN-1:0]       mem_addr;
    logic [XLEN-1:0]       mem_wdata;
    logic [1:0]            mem_size;
    logic                  redirect_valid;
    logic [XLEN-1:0]       redirect_pc;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    logic [31:0]     lfsr_state;
    logic [XLEN-1:0] next_pc;
    expect_t         exp_q[$];  // Oldest first, one entry per cycle.
    int              checks;
    int              errors;
    int              test_checks;
    int              test_errors;

    rv_slice_top dut0 (
        .clk, .rst, .instr_valid, .instr, .pc, .mem_rdata,
        .mem_re, .mem_we, .mem_addr, .mem_wdata, .mem_size,
        .redirect_valid, .redirect_pc, .wb_valid, .wb_rd, .wb_data
    );

    always #50 clk = ~clk;

    // ****************************************
    // Stimulus
    // ****************************************
    function automatic logic lfsr_bit();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic logic [31:0] gen_insn(input int group, input logic zero_rd);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [1:0]  sel;
        logic        alt;
        logic [11:0] imm;
        rd  = rand_bits(3);  // x0 to x7 only.
        rs1 = rand_bits(3);
        rs2 = rand_bits(3);
        f3  = rand_bits(3);
        sel = rand_bits(2);
        alt = rand_bits(1);
        imm = rand_bits(12);
        if (zero_rd && rand_bits(1))
            rd = '0;
        case (group)
            1: begin
                if (f3 == 3'd3 || f3 > 3'd5)
                    f3 = 3'd2;
                return {imm, rs1, f3, rd, LOAD};
            end
            2:
                return {imm[11:5], rs2, rs1, 1'b0, f3[1] & ~f3[0], f3[0], imm[4:0], STORE};
            3: begin
                if (sel == 2'd0)
                    return {imm, rs1, f3, rd, JAL};
                if (sel == 2'd1)
                    return {imm, rs1, 3'b000, rd, JALR};
                if (f3[2:1] == 2'b01)
                    f3[2] = 1'b1;   // Skip the two reserved funct3 codes.
                return {imm[11:5], rs2, rs1, f3, imm[4:0], BRANCH};
            end
            default: ;
        endcase
        if (sel == 2'd0) begin
            if (f3 != 3'd0 && f3 != 3'd5)
                alt = 1'b0;
            return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP};
        end
        if (sel == 2'd3)
            return {imm, rs1, f3, rd, (alt ? LUI : AUIPC)};
        if (f3 == 3'd1)
            imm[11:5] = 7'b0;
        if (f3 == 3'd5)
            imm[11:5] = {1'b0, alt, 5'b0};
        return {imm, rs1, f3, rd, OPIMM};
    endfunction

    function automatic logic [31:0] pick_insn(input test_kind_e kind);
        logic [2:0] r;
        r = rand_bits(3);
        case (kind)
            K_ALU:    return gen_insn(0, 1'b0);
            K_ZERO:   return gen_insn(0, 1'b1);
            K_LOAD:   return gen_insn(r[0] ? 1 : 0, 1'b0);
            K_STORE:  return gen_insn(r[0] ? 2 : 0, 1'b0);
            K_BRANCH: return gen_insn(r[0] ? 3 : 0, 1'b0);
            default: ;
        endcase
        if (r < 3'd4)
            return gen_insn(0, 1'b0);
        return gen_insn((r == 3'd4) ? 1 : (r == 3'd5) ? 2 : 3, 1'b0);
    endfunction

    // ****************************************
    // Checks
    // ****************************************
    task automatic count_check(input logic bad);
        checks++;
        test_checks++;
        if (bad) begin
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_mem(input logic exp_re, input logic exp_we,
                             input logic [XLEN-1:0] exp_addr, input logic [XLEN-1:0] exp_wdata,
                             input logic [1:0] exp_size);
        logic bad;
        bad = (mem_re !== exp_re) || (mem_we !== exp_we);
        if (exp_re || exp_we)
            bad = bad || (mem_addr !== exp_addr) || (mem_size !== exp_size);
        if (exp_we)
            bad = bad || (mem_wdata !== exp_wdata);
        count_check(bad);
        if (bad)
            $display("Mismatch at %0d ns: memory re=%b we=%b addr=%h wdata=%h size=%0d, %s",
                     $time, mem_re, mem_we, mem_addr, mem_wdata, mem_size,
                     $sformatf("expected re=%b we=%b addr=%h wdata=%h size=%0d",
                               exp_re, exp_we, exp_addr, exp_wdata, exp_size));
    endtask

    task automatic check_redirect(input logic exp_valid, input logic [XLEN-1:0] exp_pc);
        logic bad;
        bad = (redirect_valid !== exp_valid) || (exp_valid && redirect_pc !== exp_pc);
        count_check(bad);
        if (bad)
            $display("Mismatch at %0d ns: redirect valid=%b pc=%h, expected valid=%b pc=%h",
                     $time, redirect_valid, redirect_pc, exp_valid, exp_pc);
    endtask

    task automatic check_wb(input logic exp_valid, input logic [REG_ADDR_W-1:0] exp_rd,
                            input logic [XLEN-1:0] exp_data);
        logic bad;
        bad = (wb_valid !== exp_valid);
        if (exp_valid)
            bad = bad || (wb_rd !== exp_rd) || (wb_data !== exp_data);
        count_check(bad);
        if (bad)
            $display("Mismatch at %0d ns: writeback valid=%b x%0d=%h, expected valid=%b x%0d=%h",
                     $time, wb_valid, wb_rd, wb_data, exp_valid, exp_rd, exp_data);
    endtask

    // One clock: check T+2 and T+3 results, then issue.
    task automatic run_cycle(input logic issue, input logic [31:0] insn);
        expect_t old_e;
        expect_t mid_e;
        @(posedge clk);
        #5;
        old_e = exp_q.pop_front();
        mid_e = exp_q[0];
        check_mem(mid_e.mem_re, mid_e.mem_we, mid_e.addr, mid_e.wdata, mid_e.size);
        check_redirect(mid_e.redirect, mid_e.target);
        check_wb(old_e.wb, old_e.rd, old_e.wb_data);
        mem_rdata   = mem_word(mid_e.addr);
        instr_valid = issue;
        instr       = insn;
        pc          = next_pc;
        if (issue) begin
            exp_q.push_back(exec_insn(insn, next_pc));
            next_pc = next_pc + 32'd4;
        end else begin
            exp_q.push_back('0);
        end
    endtask

    function automatic logic pending();
        logic busy;
        busy = 1'b0;
        for (int i = 0; i < exp_q.size(); i++)
            busy = busy | exp_q[i].valid;
        return busy;
    endfunction

    task automatic end_test(input string name);
        $display("Test %s finished: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic run_test(input string name, input test_kind_e kind, input int count);
        logic [31:0] insn;
        logic        after_load;
        int          n;
        after_load = 1'b0;
        for (int i = 0; i < count; i++) begin
            if (after_load || rand_bits(2) == 2'd0) begin
                run_cycle(1'b0, '0);   // Bubble.
                after_load = 1'b0;
            end else begin
                insn = pick_insn(kind);
                run_cycle(1'b1, insn);
                after_load = (insn[6:0] == LOAD);
            end
        end
        n = 0;
        while (pending() && n < 8) begin
            run_cycle(1'b0, '0);
            n++;
        end
        if (pending()) begin
            errors++;
            test_errors++;
            $display("Test %s did not drain within 8 cycles", name);
        end
        end_test(name);
    endtask

    initial begin
        int n;
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        mem_rdata   = '0;
        lfsr_state  = 32'd58;
        next_pc     = 32'h0000_1000;
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
        clear_regs();
        repeat (3)
            exp_q.push_back('0);
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;
        n   = 0;
        while ((mem_re || mem_we || redirect_valid || wb_valid) && n < 5) begin
            @(posedge clk);
            n++;
        end
        if (n == 5) begin
            errors++;
            $display("Outputs still active 5 cycles after reset");
        end
        repeat (20)
            run_cycle(1'b0, '0);
        end_test("idle");
        run_test("alu", K_ALU, 120);
        run_test("load", K_LOAD, 120);
        run_test("store", K_STORE, 100);
        run_test("branch", K_BRANCH, 120);
        run_test("x0", K_ZERO, 100);
        run_test("mixed", K_MIXED, 300);
        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== compile.f ====
hw/core_pkg.sv
hw/stage_if.sv
hw/reg_file.sv
hw/insn_decode.sv
hw/alu_execute.sv
hw/result_stage.sv
hw/rv_slice_top.sv
bench/rv_ref_model.sv
bench/tb_rv_slice.sv
